// File: sim.f
+incdir+tb
hw/rvfi_trace_pkg.sv
hw/trace_fifo.sv
hw/rvfi_trace_map.sv
hw/trace_apb_regs.sv
hw/rvfi_trace_top.sv
tb/tb_rvfi_trace.sv

// File: Bender.yml
package:
  name: rvfi_trace

sources:
  # RTL in compile order
  - hw/rvfi_trace_pkg.sv
  - hw/trace_fifo.sv
  - hw/rvfi_trace_map.sv
  - hw/trace_apb_regs.sv
  - hw/rvfi_trace_top.sv
  # Testbench
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_rvfi_trace.sv

// File: tb/tb_steps.svh
// Directed step table for the trace monitor testbench, applied in order by the step loop
// Columns: op, register offset, write data or retired PC, expected read data, expected pslverr

localparam int NUM_STEPS = 80;

localparam step_t STEPS [NUM_STEPS] = '{
  // Reset values
  '{OP_RD, REG_STATUS, 0, 'h10, 0},        '{OP_RD, REG_RETIRED, 0, 0, 0},
  '{OP_RD, REG_UNKNOWN, 0, 0, 0},          '{OP_RD, REG_CTRL, 0, 0, 0},
  // Three table entries, func 1..3 and lines 10, 20, 30
  '{OP_WR, REG_MAP_IDX, 0, 0, 0},          '{OP_WR, REG_MAP_PC, 'h1000, 0, 0},
  '{OP_WR, REG_MAP_INFO, 'h0001_000A, 0, 0},
  '{OP_WR, REG_MAP_IDX, 1, 0, 0},          '{OP_WR, REG_MAP_PC, 'h1004, 0, 0},
  '{OP_WR, REG_MAP_INFO, 'h0002_0014, 0, 0},
  '{OP_WR, REG_MAP_IDX, 2, 0, 0},          '{OP_WR, REG_MAP_PC, 'h1008, 0, 0},
  '{OP_WR, REG_MAP_INFO, 'h0003_001E, 0, 0},
  // Enable and retire mapped PCs out of table order
  '{OP_WR, REG_CTRL, 1, 0, 0},             '{OP_RET, 0, 'h1004, 0, 0},
  '{OP_RET, 0, 'h1000, 0, 0},              '{OP_RET, 0, 'h1008, 0, 0},
  // Drain in retirement order, fill drops by one per pop
  '{OP_RD, REG_STATUS, 0, 'h03, 0},        '{OP_RD, REG_REC_INFO, 0, 'h0102_0014, 0},
  '{OP_RD, REG_REC_PC, 0, 'h1004, 0},      '{OP_RD, REG_STATUS, 0, 'h02, 0},
  '{OP_RD, REG_REC_INFO, 0, 'h0101_000A, 0},
  '{OP_RD, REG_REC_PC, 0, 'h1000, 0},      '{OP_RD, REG_STATUS, 0, 'h01, 0},
  '{OP_RD, REG_REC_INFO, 0, 'h0103_001E, 0},
  '{OP_RD, REG_REC_PC, 0, 'h1008, 0},      '{OP_RD, REG_STATUS, 0, 'h10, 0},
  // Unmapped PC gives the sentinel record
  '{OP_RET, 0, 'h2000, 0, 0},              '{OP_RD, REG_REC_INFO, 0, 'h0000_FFFF, 0},
  '{OP_RD, REG_REC_PC, 0, 'h2000, 0},      '{OP_RD, REG_UNKNOWN, 0, 1, 0},
  '{OP_RD, REG_RETIRED, 0, 4, 0},
  // Capture disabled, nothing queued or counted
  '{OP_WR, REG_CTRL, 0, 0, 0},             '{OP_RET, 0, 'h1000, 0, 0},
  '{OP_RET, 0, 'h3000, 0, 0},              '{OP_RD, REG_STATUS, 0, 'h10, 0},
  '{OP_RD, REG_RETIRED, 0, 4, 0},          '{OP_RD, REG_UNKNOWN, 0, 1, 0},
  '{OP_WR, REG_CTRL, 1, 0, 0},
  // Nine retirements without pops, the last one is dropped
  '{OP_RET, 0, 'h1000, 0, 0},              '{OP_RET, 0, 'h1004, 0, 0},
  '{OP_RET, 0, 'h1008, 0, 0},              '{OP_RET, 0, 'h4000, 0, 0},
  '{OP_RET, 0, 'h1000, 0, 0},              '{OP_RET, 0, 'h1004, 0, 0},
  '{OP_RET, 0, 'h4004, 0, 0},              '{OP_RET, 0, 'h1008, 0, 0},
  '{OP_RET, 0, 'h4008, 0, 0},              '{OP_RD, REG_STATUS, 0, 'h68, 0},
  '{OP_RD, REG_REC_PC, 0, 'h1000, 0},      '{OP_RD, REG_REC_PC, 0, 'h1004, 0},
  '{OP_RD, REG_REC_PC, 0, 'h1008, 0},      '{OP_RD, REG_REC_PC, 0, 'h4000, 0},
  '{OP_RD, REG_REC_PC, 0, 'h1000, 0},      '{OP_RD, REG_REC_PC, 0, 'h1004, 0},
  '{OP_RD, REG_REC_PC, 0, 'h4004, 0},      '{OP_RD, REG_REC_PC, 0, 'h1008, 0},
  // Empty with overflow still set, then cleared while enable stays on
  '{OP_RD, REG_STATUS, 0, 'h50, 0},        '{OP_WR, REG_CTRL, 5, 0, 0},
  '{OP_RD, REG_STATUS, 0, 'h10, 0},        '{OP_RD, REG_RETIRED, 0, 13, 0},
  '{OP_RD, REG_UNKNOWN, 0, 4, 0},
  // Clear the map, then rewrite one entry at index 5
  '{OP_WR, REG_CTRL, 3, 0, 0},             '{OP_RET, 0, 'h1004, 0, 0},
  '{OP_RD, REG_REC_INFO, 0, 'h0000_FFFF, 0},
  '{OP_RD, REG_REC_PC, 0, 'h1004, 0},      '{OP_WR, REG_MAP_IDX, 5, 0, 0},
  '{OP_WR, REG_MAP_PC, 'h1004, 0, 0},      '{OP_WR, REG_MAP_INFO, 'h0007_0063, 0, 0},
  '{OP_RET, 0, 'h1004, 0, 0},              '{OP_RD, REG_REC_INFO, 0, 'h0107_0063, 0},
  '{OP_RD, REG_REC_PC, 0, 'h1004, 0},
  // Unmapped offset and empty pops
  '{OP_WR, 8'h24, 'hFFFF_FFFF, 0, 1},      '{OP_RD, 8'h24, 0, 0, 1},
  '{OP_RD, REG_CTRL, 0, 1, 0},             '{OP_RD, REG_STATUS, 0, 'h10, 0},
  '{OP_RD, REG_REC_PC, 0, 0, 0},           '{OP_RD, REG_STATUS, 0, 'h10, 0},
  '{OP_RD, REG_RETIRED, 0, 15, 0},         '{OP_RD, REG_UNKNOWN, 0, 5, 0}
};

// File: tb/tb_rvfi_trace.sv
// Testbench for the retirement trace monitor
// Runs the directed step table and then a seeded random pass checked against a model table

`timescale 1ns/1ps

module tb_rvfi_trace;

  import rvfi_trace_pkg::*;

  ////////////////////////////////////////////////////////////
  // Step table
  ////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {OP_WR, OP_RD, OP_RET} step_op_e;

  typedef struct packed {
    step_op_e  op;
    apb_addr_t addr;
    apb_data_t data;
    apb_data_t exp;
    logic      err;
  } step_t;

  `include "tb_steps.svh"

  localparam int STEP_LIMIT   = 8;
  localparam int RUN_LIMIT    = 5000;
  localparam int RAND_RETIRES = 40;
  // Indices loaded for the random pass where 9 and 13 share a PC
  localparam map_idx_t LOADED [4] = '{4'd2, 4'd6, 4'd9, 4'd13};

  logic        clk;
  logic        arst_n;
  logic        rvfi_valid;
  pc_t         rvfi_pc_rdata;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  int unsigned cycle;
  int          errors;
  integer      seed;

  // Model of the address table
  pc_t   model_pc    [MAP_ENTRIES];
  func_t model_func  [MAP_ENTRIES];
  line_t model_line  [MAP_ENTRIES];
  logic  model_valid [MAP_ENTRIES];

  rvfi_trace_top DUT (
    .clk           (clk),
    .arst_n        (arst_n),
    .rvfi_valid    (rvfi_valid),
    .rvfi_pc_rdata (rvfi_pc_rdata),
    .apb_req       (apb_req),
    .apb_rsp       (apb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  ////////////////////////////////////////////////////////////
  // Failure reporting
  ////////////////////////////////////////////////////////////
  task automatic report_error(input string msg);
    errors++;
    $display("** Error at %0t ns: %s", $time, msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic abort_run(input string msg);
    errors++;
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "Run aborted");
  endtask

  task automatic check_word(input apb_data_t got, input apb_data_t exp, input string what);
    assert (got === exp)
    else report_error($sformatf("%s: got %h, expected %h", what, got, exp));
  endtask

  ////////////////////////////////////////////////////////////
  // Bus drivers
  ////////////////////////////////////////////////////////////

  // Setup then access cycle, sampled in the middle of the access cycle
  task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                          output apb_data_t rdata, output logic err);
    @(posedge clk);
    #2;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge clk);
    #2;
    apb_req.penable = 1'b1;
    #6;
    // No wait states, so pready is already high in the access cycle
    check_word(apb_rsp.pready, 1, $sformatf("pready on access to %h", addr));
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    // Write lands at this edge
    @(posedge clk);
    #2;
    apb_req = '0;
  endtask

  task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
    apb_data_t rdata;
    logic      err;
    apb_xfer(1'b1, addr, data, rdata, err);
    check_word(err, 0, $sformatf("pslverr on write to %h", addr));
  endtask

  task automatic read_reg(input apb_addr_t addr, output apb_data_t data);
    logic err;
    apb_xfer(1'b0, addr, '0, data, err);
    check_word(err, 0, $sformatf("pslverr on read of %h", addr));
  endtask

  // One retirement with no back-pressure from the monitor
  task automatic retire_pc(input pc_t pc);
    @(posedge clk);
    #2;
    rvfi_valid    = 1'b1;
    rvfi_pc_rdata = pc;
    @(posedge clk);
    #2;
    rvfi_valid = 1'b0;
  endtask

  // Commit one entry and mirror it in the model
  task automatic load_entry(input map_idx_t idx, input pc_t pc, input func_t func,
                            input line_t line);
    write_reg(REG_MAP_IDX, {28'h0, idx});
    write_reg(REG_MAP_PC, pc);
    write_reg(REG_MAP_INFO, {8'h00, func, line});
    model_pc[idx]    = pc;
    model_func[idx]  = func;
    model_line[idx]  = line;
    model_valid[idx] = 1'b1;
  endtask

  // REC_INFO word predicted from the model by the first match from index 0 up
  function automatic apb_data_t expected_info(input pc_t pc);
    apb_data_t info;
    logic      found;
    info  = 32'h0000_FFFF;
    found = 1'b0;
    for (int i = 0; i < MAP_ENTRIES; i++) begin
      if (!found && model_valid[i] && model_pc[i] == pc) begin
        found = 1'b1;
        info  = {7'h00, 1'b1, model_func[i], model_line[i]};
      end
    end
    return info;
  endfunction

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin : main
    apb_data_t   rdata;
    apb_data_t   exp_info;
    apb_data_t   base_ret;
    apb_data_t   base_unk;
    logic        err;
    int unsigned start;
    int          misses;
    logic [31:0] r;
    pc_t         pc;

    seed          = 32'h1668_afe3;
    cycle         = 0;
    errors        = 0;
    arst_n        = 1'b0;
    rvfi_valid    = 1'b0;
    rvfi_pc_rdata = '0;
    apb_req       = '0;
    for (int i = 0; i < MAP_ENTRIES; i++) begin
      model_valid[i] = 1'b0;
    end
    repeat (4) @(posedge clk);
    #2;
    arst_n = 1'b1;

    // Directed steps
    for (int i = 0; i < NUM_STEPS; i++) begin
      start = cycle;
      if (STEPS[i].op == OP_RET) begin
        retire_pc(STEPS[i].data);
      end else begin
        apb_xfer(STEPS[i].op == OP_WR, STEPS[i].addr, STEPS[i].data, rdata, err);
        if (STEPS[i].op == OP_RD) begin
          check_word(rdata, STEPS[i].exp, $sformatf("step %0d read of %h", i, STEPS[i].addr));
        end
        check_word(err, STEPS[i].err, $sformatf("step %0d pslverr", i));
      end
      if (cycle - start > STEP_LIMIT) begin
        abort_run($sformatf("Step %0d took more than %0d cycles", i, STEP_LIMIT));
      end
    end

    // Random pass on a freshly loaded table
    write_reg(REG_CTRL, 32'h3);
    for (int i = 0; i < MAP_ENTRIES; i++) begin
      model_valid[i] = 1'b0;
    end
    load_entry(LOADED[0], 32'h5000, 8'h21, 16'd200);
    load_entry(LOADED[1], 32'h5040, 8'h22, 16'd300);
    load_entry(LOADED[2], 32'h5100, 8'h23, 16'd400);
    load_entry(LOADED[3], 32'h5100, 8'h24, 16'd500);
    read_reg(REG_RETIRED, base_ret);
    read_reg(REG_UNKNOWN, base_unk);
    misses = 0;
    for (int n = 0; n < RAND_RETIRES; n++) begin
      r = $random(seed);
      // Odd draws take a loaded PC and even ones a nearby address that may miss
      if (r[0]) begin
        pc = model_pc[LOADED[r[2:1]]];
      end else begin
        pc = 32'h5000 + {r[11:4], 2'b00};
      end
      exp_info = expected_info(pc);
      if (!exp_info[24]) begin
        misses++;
      end
      retire_pc(pc);
      read_reg(REG_REC_INFO, rdata);
      check_word(rdata, exp_info, $sformatf("random retire %0d info for pc %h", n, pc));
      read_reg(REG_REC_PC, rdata);
      check_word(rdata, pc, $sformatf("random retire %0d pc", n));
    end
    read_reg(REG_RETIRED, rdata);
    check_word(rdata, base_ret + RAND_RETIRES, "retired count after random pass");
    read_reg(REG_UNKNOWN, rdata);
    check_word(rdata, base_unk + misses, "unknown count after random pass");
    read_reg(REG_STATUS, rdata);
    check_word(rdata, 32'h10, "status after random pass");

    if (errors == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      $display("SOME TESTS FAILED");
      $fatal(1, "Checks failed");
    end
  end

  // Whole-run limit
  initial begin : watchdog
    repeat (RUN_LIMIT) @(posedge clk);
    abort_run($sformatf("Run did not finish within %0d cycles", RUN_LIMIT));
  end

endmodule

// File: hw/rvfi_trace_top.sv
// Top level of the retirement trace monitor
// Connects the lookup table, the record FIFO and the APB registers

`timescale 1ns/1ps

module rvfi_trace_top (
  input  logic                     clk,
  input  logic                     arst_n,
  // Core retirement port, no back-pressure
  input  logic                     rvfi_valid,
  input  rvfi_trace_pkg::pc_t      rvfi_pc_rdata,
  // Software access
  input  rvfi_trace_pkg::apb_req_t apb_req,
  output rvfi_trace_pkg::apb_rsp_t apb_rsp
);

  import rvfi_trace_pkg::*;

  ////////////////////////////////////////////////////////////
  // Internal wiring
  ////////////////////////////////////////////////////////////

  // Table control
  logic     capture_en;
  logic     map_clear;
  logic     map_we;
  map_idx_t map_idx;
  pc_t      map_pc;
  func_t    map_func;
  line_t    map_line;

  // Record path
  logic       rec_valid;
  trace_rec_t rec;
  trace_rec_t head;

  // FIFO status and control
  fifo_cnt_t fill;
  logic      empty;
  logic      full;
  logic      overflow;
  logic      rec_pop;
  logic      ovf_clear;

  // Counters
  cnt_t retired_cnt;
  cnt_t unknown_cnt;

  // PC lookup and record generation
  rvfi_trace_map u_map (
    .clk           (clk),
    .arst_n        (arst_n),
    .rvfi_valid    (rvfi_valid),
    .rvfi_pc_rdata (rvfi_pc_rdata),
    .capture_en    (capture_en),
    .map_clear     (map_clear),
    .map_we        (map_we),
    .map_idx       (map_idx),
    .map_pc        (map_pc),
    .map_func      (map_func),
    .map_line      (map_line),
    .rec_valid     (rec_valid),
    .rec           (rec),
    .retired_cnt   (retired_cnt),
    .unknown_cnt   (unknown_cnt)
  );

  // Record queue
  trace_fifo u_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .push      (rec_valid),
    .wdata     (rec),
    .pop       (rec_pop),
    .ovf_clear (ovf_clear),
    .head      (head),
    .fill      (fill),
    .empty     (empty),
    .full      (full),
    .overflow  (overflow)
  );

  // Register block
  trace_apb_regs u_regs (
    .clk         (clk),
    .arst_n      (arst_n),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp),
    .retired_cnt (retired_cnt),
    .unknown_cnt (unknown_cnt),
    .head        (head),
    .fill        (fill),
    .empty       (empty),
    .full        (full),
    .overflow    (overflow),
    .capture_en  (capture_en),
    .map_clear   (map_clear),
    .map_we      (map_we),
    .map_idx     (map_idx),
    .map_pc      (map_pc),
    .map_func    (map_func),
    .map_line    (map_line),
    .rec_pop     (rec_pop),
    .ovf_clear   (ovf_clear)
  );

endmodule

// File: hw/trace_apb_regs.sv
// APB register block of the trace monitor
// Holds control state, issues table and FIFO strobes and muxes read data

`timescale 1ns/1ps

module trace_apb_regs (
  input  logic                       clk,
  input  logic                       arst_n,
  // Software bus
  input  rvfi_trace_pkg::apb_req_t   apb_req,
  output rvfi_trace_pkg::apb_rsp_t   apb_rsp,
  // Status from the map and the FIFO
  input  rvfi_trace_pkg::cnt_t       retired_cnt,
  input  rvfi_trace_pkg::cnt_t       unknown_cnt,
  input  rvfi_trace_pkg::trace_rec_t head,
  input  rvfi_trace_pkg::fifo_cnt_t  fill,
  input  logic                       empty,
  input  logic                       full,
  input  logic                       overflow,
  // Table control
  output logic                       capture_en,
  output logic                       map_clear,
  output logic                       map_we,
  output rvfi_trace_pkg::map_idx_t   map_idx,
  output rvfi_trace_pkg::pc_t        map_pc,
  output rvfi_trace_pkg::func_t      map_func,
  output rvfi_trace_pkg::line_t      map_line,
  // FIFO control
  output logic                       rec_pop,
  output logic                       ovf_clear
);

  import rvfi_trace_pkg::*;

  logic      access;
  logic      addr_ok;
  logic      wr_en;
  logic      rd_en;
  apb_data_t rdata;

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////

  // Second phase of the transfer with no wait states
  assign access = apb_req.psel & apb_req.penable;

  always_comb begin
    case (apb_req.paddr)
      REG_CTRL, REG_STATUS, REG_MAP_IDX, REG_MAP_PC, REG_MAP_INFO,
      REG_REC_INFO, REG_REC_PC, REG_RETIRED, REG_UNKNOWN: addr_ok = 1'b1;
      default: addr_ok = 1'b0;
    endcase
  end

  // Unmapped offsets never reach the strobes below
  assign wr_en = access & addr_ok & apb_req.pwrite;
  assign rd_en = access & addr_ok & ~apb_req.pwrite;

  ////////////////////////////////////////////////////////////
  // Control registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      capture_en <= 1'b0;
      map_idx    <= '0;
      map_pc     <= '0;
    end else if (wr_en) begin
      case (apb_req.paddr)
        REG_CTRL:    capture_en <= apb_req.pwdata[0];
        REG_MAP_IDX: map_idx    <= apb_req.pwdata[3:0];
        REG_MAP_PC:  map_pc     <= apb_req.pwdata;
        default: ;
      endcase
    end
  end

  // One-cycle strobes that act at the edge ending the access cycle
  assign map_clear = wr_en & (apb_req.paddr == REG_CTRL) & apb_req.pwdata[1];
  assign ovf_clear = wr_en & (apb_req.paddr == REG_CTRL) & apb_req.pwdata[2];
  assign map_we    = wr_en & (apb_req.paddr == REG_MAP_INFO);

  // Entry payload comes straight from the commit write
  assign map_line = apb_req.pwdata[15:0];
  assign map_func = apb_req.pwdata[23:16];

  // Reading the PC word consumes the head record
  assign rec_pop = rd_en & (apb_req.paddr == REG_REC_PC) & ~empty;

  ////////////////////////////////////////////////////////////
  // Read data
  ////////////////////////////////////////////////////////////

  always_comb begin
    rdata = '0;
    case (apb_req.paddr)
      REG_CTRL:    rdata[0]   = capture_en;
      REG_STATUS:  rdata[6:0] = {overflow, full, empty, fill};
      REG_MAP_IDX: rdata[3:0] = map_idx;
      REG_MAP_PC:  rdata      = map_pc;
      // Record words read as zero while nothing is queued
      REG_REC_INFO: begin
        if (!empty) begin
          rdata[24:0] = {head.hit, head.func, head.line};
        end
      end
      REG_REC_PC: begin
        if (!empty) begin
          rdata = head.pc;
        end
      end
      REG_RETIRED: rdata = retired_cnt;
      REG_UNKNOWN: rdata = unknown_cnt;
      default:     rdata = '0;
    endcase
  end

  assign apb_rsp.prdata  = rd_en ? rdata : '0;
  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = access & ~addr_ok;

endmodule

// File: hw/rvfi_trace_map.sv
// PC-to-source lookup table with per-retirement trace record generation
// Table is loaded through the register block, records feed the trace FIFO

`timescale 1ns/1ps

module rvfi_trace_map (
  input  logic                    clk,
  input  logic                    arst_n,
  // Retirement port from the core
  input  logic                    rvfi_valid,
  input  rvfi_trace_pkg::pc_t     rvfi_pc_rdata,
  // Control from the register block
  input  logic                    capture_en,
  input  logic                    map_clear,
  input  logic                    map_we,
  input  rvfi_trace_pkg::map_idx_t map_idx,
  input  rvfi_trace_pkg::pc_t     map_pc,
  input  rvfi_trace_pkg::func_t   map_func,
  input  rvfi_trace_pkg::line_t   map_line,
  // Record towards the FIFO
  output logic                    rec_valid,
  output rvfi_trace_pkg::trace_rec_t rec,
  // Event counters
  output rvfi_trace_pkg::cnt_t    retired_cnt,
  output rvfi_trace_pkg::cnt_t    unknown_cnt
);

  import rvfi_trace_pkg::*;

  // One table slot
  typedef struct packed {
    pc_t   pc;
    func_t func;
    line_t line;
  } map_entry_t;

  map_entry_t             tbl [MAP_ENTRIES];
  logic [MAP_ENTRIES-1:0] tbl_valid;

  logic     hit;
  map_idx_t hit_idx;

  ////////////////////////////////////////////////////////////
  // Table storage
  ////////////////////////////////////////////////////////////

  // Entry payload, written on commit
  always_ff @(posedge clk) begin
    if (map_we) begin
      tbl[map_idx] <= '{pc: map_pc, func: map_func, line: map_line};
    end
  end

  // Valid bits, clear-map drops everything first
  // A commit in the same cycle as a clear still lands
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tbl_valid <= '0;
    end else begin
      if (map_clear) begin
        tbl_valid <= '0;
      end
      if (map_we) begin
        tbl_valid[map_idx] <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Parallel lookup
  ////////////////////////////////////////////////////////////

  // Walk downwards so the lowest matching index is the one kept
  // Uses the table contents before any commit at this edge
  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int i = MAP_ENTRIES - 1; i >= 0; i--) begin
      if (tbl_valid[i] && (tbl[i].pc == rvfi_pc_rdata)) begin
        hit     = 1'b1;
        hit_idx = map_idx_t'(i);
      end
    end
  end

  // Record is captured by the FIFO at the retirement edge
  assign rec_valid = rvfi_valid & capture_en;

  always_comb begin
    rec.hit  = hit;
    rec.pc   = rvfi_pc_rdata;
    // Misses carry the sentinel line and function id zero
    rec.func = hit ? tbl[hit_idx].func : '0;
    rec.line = hit ? tbl[hit_idx].line : LINE_UNKNOWN;
  end

  ////////////////////////////////////////////////////////////
  // Counters
  ////////////////////////////////////////////////////////////

  // Count whether or not the FIFO accepts the record
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      retired_cnt <= '0;
      unknown_cnt <= '0;
    end else if (rec_valid) begin
      retired_cnt <= retired_cnt + 1'b1;
      if (!hit) begin
        unknown_cnt <= unknown_cnt + 1'b1;
      end
    end
  end

endmodule

// File: hw/trace_fifo.sv
// Circular buffer for trace records, drained by software over APB
// Drops records when full and flags this with a sticky overflow bit

`timescale 1ns/1ps

module trace_fifo (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       push,
  input  rvfi_trace_pkg::trace_rec_t wdata,
  input  logic                       pop,
  input  logic                       ovf_clear,
  output rvfi_trace_pkg::trace_rec_t head,
  output rvfi_trace_pkg::fifo_cnt_t  fill,
  output logic                       empty,
  output logic                       full,
  output logic                       overflow
);

  import rvfi_trace_pkg::*;

  trace_rec_t mem [FIFO_DEPTH];
  fifo_ptr_t  wr_ptr;
  fifo_ptr_t  rd_ptr;
  logic       do_pop;
  logic       do_push;

  assign empty = (fill == '0);
  assign full  = (fill == fifo_cnt_t'(FIFO_DEPTH));

  // Pop goes first, so a full buffer still accepts a push during a pop
  assign do_pop  = pop & ~empty;
  assign do_push = push & (~full | do_pop);

  assign head = mem[rd_ptr];

  // Record slots
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= wdata;
    end
  end

  // Pointers wrap naturally at depth 8
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fill     <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        fill <= fill + 1'b1;
      end else if (do_pop && !do_push) begin
        fill <= fill - 1'b1;
      end
      // Sticky until software clears it, a new drop wins over the clear
      if (ovf_clear) begin
        overflow <= 1'b0;
      end
      if (push && !do_push) begin
        overflow <= 1'b1;
      end
    end
  end

endmodule

// File: hw/rvfi_trace_pkg.sv
// Shared types, sizes, register offsets and bus structs for the trace monitor
// Modules take what they need by a wildcard import inside their body

package rvfi_trace_pkg;

  ////////////////////////////////////////////////////////////
  // Widths that carry a meaning
  ////////////////////////////////////////////////////////////
  typedef logic [31:0] pc_t;
  typedef logic [15:0] line_t;
  typedef logic [7:0]  func_t;
  typedef logic [31:0] cnt_t;
  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // Address table size
  localparam int unsigned MAP_ENTRIES = 16;
  typedef logic [3:0] map_idx_t;

  // Record FIFO size, fill level needs one bit more than the pointers
  localparam int unsigned FIFO_DEPTH = 8;
  typedef logic [3:0] fifo_cnt_t;
  typedef logic [2:0] fifo_ptr_t;

  // Line number reported for an address missing from the table
  localparam line_t LINE_UNKNOWN = '1;

  ////////////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic  hit;
    func_t func;
    line_t line;
    pc_t   pc;
  } trace_rec_t;

  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

  // Register offsets
  localparam apb_addr_t REG_CTRL     = 8'h00;
  localparam apb_addr_t REG_STATUS   = 8'h04;
  localparam apb_addr_t REG_MAP_IDX  = 8'h08;
  localparam apb_addr_t REG_MAP_PC   = 8'h0C;
  localparam apb_addr_t REG_MAP_INFO = 8'h10;
  localparam apb_addr_t REG_REC_INFO = 8'h14;
  localparam apb_addr_t REG_REC_PC   = 8'h18;
  localparam apb_addr_t REG_RETIRED  = 8'h1C;
  localparam apb_addr_t REG_UNKNOWN  = 8'h20;

endpackage
